//--- hw/lb_pkg.sv
// Shared sizes, vector types, port state encoding and host register codes
`default_nettype none

package lb_pkg;

  localparam int IF_COUNT   = 3;
  localparam int CORE_COUNT = 8;
  localparam int SLOT_COUNT = 16;
  localparam int DATA_WIDTH = 64;
  localparam int TAG_WIDTH  = 5;

  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int PORT_WIDTH    = $clog2(IF_COUNT);
  // One extra bit so a full pool of SLOT_COUNT fits
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1);

  typedef logic [CORE_ID_WIDTH-1:0]           core_id_t;
  typedef logic [TAG_WIDTH-1:0]               tag_t;
  typedef logic [SLOT_WIDTH-1:0]              slot_cnt_t;
  typedef logic [PORT_WIDTH-1:0]              port_id_t;
  typedef logic [DATA_WIDTH-1:0]              data_t;
  typedef logic [CORE_COUNT-1:0]              core_mask_t;
  typedef logic [IF_COUNT-1:0]                port_mask_t;
  // Destination of a beat, core in the upper bits and tag below
  typedef logic [CORE_ID_WIDTH+TAG_WIDTH-1:0] dest_t;

  typedef enum logic [1:0] {
    STALL = 2'b00,  // No descriptor, input held off
    FIRST = 2'b01,  // Descriptor ready for the next packet
    WAIT  = 2'b10,  // Packet running, waiting for the next descriptor
    MID   = 2'b11   // Packet running, next descriptor already held
  } port_state_t;

  // Bit 4 is the port register select, bits 3:0 the register
  localparam logic [4:0] REG_ENABLED   = 5'h00;
  localparam logic [4:0] REG_INCOME    = 5'h01;
  localparam logic [4:0] REG_SLOTS     = 5'h03;
  localparam logic [4:0] REG_PORT_STAT = 5'h10;
  localparam logic [4:0] REG_RELEASE   = 5'h12;

  localparam logic [31:0] READ_DEFAULT = 32'hFEFE_FEFE;

endpackage

`default_nettype wire

//--- hw/lb_if.sv
// Descriptor handoff interface between slot pool and dispatcher
// Status interface shared by the host registers, slot pool and dispatcher
`timescale 1ns/1ps
`default_nettype none

interface desc_if;
  import lb_pkg::*;

  logic     desc_valid;
  core_id_t desc_core;
  tag_t     desc_tag;
  logic     desc_pop;

  modport producer (
    output desc_valid, desc_core, desc_tag,
    input  desc_pop
  );

  modport consumer (
    input  desc_valid, desc_core, desc_tag,
    output desc_pop
  );

endinterface

interface lb_status_if #(
  parameter int IF_COUNT   = lb_pkg::IF_COUNT,
  parameter int CORE_COUNT = lb_pkg::CORE_COUNT
);
  import lb_pkg::*;

  core_mask_t                  enabled_cores;
  core_mask_t                  income_cores;
  port_mask_t                  release_desc;
  slot_cnt_t   [CORE_COUNT-1:0] slot_counts;
  port_state_t [IF_COUNT-1:0]   port_states;
  dest_t       [IF_COUNT-1:0]   port_descs;

  modport regs (
    output enabled_cores, income_cores, release_desc,
    input  slot_counts, port_states, port_descs
  );

  modport pool (
    input  income_cores,
    output slot_counts
  );

  modport dispatch (
    input  release_desc,
    output port_states, port_descs
  );

endinterface

`default_nettype wire

//--- hw/slot_pool.sv
// Free-slot counters per core, selection of the emptiest incoming core
// and per-core tag sequence counters
`timescale 1ns/1ps
`default_nettype none

module slot_pool #(
  parameter int CORE_COUNT = lb_pkg::CORE_COUNT,
  parameter int SLOT_COUNT = lb_pkg::SLOT_COUNT
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             slot_return_valid,
  input  lb_pkg::core_id_t slot_return_core,
  desc_if.producer         desc,
  lb_status_if.pool        status
);
  import lb_pkg::*;

  slot_cnt_t [CORE_COUNT-1:0] slot_cnt;
  tag_t      [CORE_COUNT-1:0] tag_cnt;
  logic      [CORE_COUNT-1:0] take;
  logic      [CORE_COUNT-1:0] give;

  slot_cnt_t best_cnt;
  core_id_t  best_core;
  logic      best_found;

  // Max finder over incoming cores, strict compare keeps the lowest index on a tie
  always_comb begin
    best_found = 1'b0;
    best_cnt   = '0;
    best_core  = '0;
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (status.income_cores[i] && (slot_cnt[i] != '0) &&
          (!best_found || (slot_cnt[i] > best_cnt))) begin
        best_found = 1'b1;
        best_cnt   = slot_cnt[i];
        best_core  = core_id_t'(i);
      end
    end
  end

  assign desc.desc_valid    = best_found;
  assign desc.desc_core     = best_core;
  assign desc.desc_tag      = tag_cnt[best_core];
  assign status.slot_counts = slot_cnt;

  always_comb begin
    for (int i = 0; i < CORE_COUNT; i++) begin
      take[i] = desc.desc_pop && (desc.desc_core == core_id_t'(i));
      give[i] = slot_return_valid && (slot_return_core == core_id_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < CORE_COUNT; i++) begin
        slot_cnt[i] <= slot_cnt_t'(SLOT_COUNT);
        tag_cnt[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < CORE_COUNT; i++) begin
        // Pop and return on the same core cancel out
        if (give[i] && !take[i]) begin
          if (slot_cnt[i] < slot_cnt_t'(SLOT_COUNT)) begin
            slot_cnt[i] <= slot_cnt[i] + 1'b1;
          end
        end else if (take[i] && !give[i]) begin
          slot_cnt[i] <= slot_cnt[i] - 1'b1;
        end
        // Tag wraps naturally at its width
        if (take[i]) begin
          tag_cnt[i] <= tag_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/desc_dispatch.sv
// Per-port descriptor FSMs, next and packet descriptor registers,
// and the round-robin arbiter for descriptor requests
`timescale 1ns/1ps
`default_nettype none

module desc_dispatch #(
  parameter int IF_COUNT = lb_pkg::IF_COUNT
) (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic        [IF_COUNT-1:0]   in_tvalid,
  input  logic        [IF_COUNT-1:0]   in_tlast,
  input  logic        [IF_COUNT-1:0]   in_tready,
  desc_if.consumer                     desc,
  lb_status_if.dispatch                status,
  output logic        [IF_COUNT-1:0]   port_open,
  output lb_pkg::dest_t [IF_COUNT-1:0] port_dest
);
  import lb_pkg::*;

  port_state_t [IF_COUNT-1:0] port_state;
  dest_t       [IF_COUNT-1:0] next_desc;
  dest_t       [IF_COUNT-1:0] pkt_desc;

  logic [IF_COUNT-1:0] acc;
  logic [IF_COUNT-1:0] last;
  logic [IF_COUNT-1:0] req;
  logic [IF_COUNT-1:0] got;

  port_id_t rr_ptr;
  port_id_t grant_idx;
  logic     grant_found;

  assign acc  = in_tvalid & in_tready;
  assign last = acc & in_tlast;

  // Ask for a descriptor when none is held, or as soon as a packet starts
  always_comb begin
    for (int p = 0; p < IF_COUNT; p++) begin
      req[p] = (port_state[p] == STALL) || (port_state[p] == WAIT) ||
               ((port_state[p] == FIRST) && acc[p]);
    end
  end

  // Search starts at the pointer and wraps around the ports
  always_comb begin : arb
    int idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < IF_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % IF_COUNT;
      if (!grant_found && req[idx]) begin
        grant_found = 1'b1;
        grant_idx   = port_id_t'(idx);
      end
    end
  end

  assign desc.desc_pop = desc.desc_valid && grant_found;

  always_comb begin
    for (int p = 0; p < IF_COUNT; p++) begin
      got[p]       = desc.desc_pop && (grant_idx == port_id_t'(p));
      port_open[p] = (port_state[p] != STALL);
      // A packet's first beat takes the next descriptor directly
      port_dest[p] = (port_state[p] == FIRST) ? next_desc[p] : pkt_desc[p];
    end
  end

  assign status.port_states = port_state;
  assign status.port_descs  = next_desc;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rr_ptr <= '0;
      for (int p = 0; p < IF_COUNT; p++) begin
        port_state[p] <= STALL;
        next_desc[p]  <= '0;
      end
    end else begin
      if (desc.desc_pop) begin
        rr_ptr <= (int'(grant_idx) == IF_COUNT - 1) ? '0 : grant_idx + 1'b1;
      end
      for (int p = 0; p < IF_COUNT; p++) begin
        if (got[p]) begin
          next_desc[p] <= {desc.desc_core, desc.desc_tag};
        end
        case (port_state[p])
          STALL: if (got[p]) port_state[p] <= FIRST;
          FIRST: begin
            // Single beat packet may also pick up its successor here
            if (last[p]) begin
              port_state[p] <= got[p] ? FIRST : STALL;
            end else if (acc[p]) begin
              port_state[p] <= got[p] ? MID : WAIT;
            end else if (status.release_desc[p]) begin
              port_state[p] <= STALL;
            end
          end
          WAIT: begin
            if (got[p] && last[p]) begin
              port_state[p] <= FIRST;
            end else if (got[p]) begin
              port_state[p] <= MID;
            end else if (last[p]) begin
              port_state[p] <= STALL;
            end
          end
          MID: begin
            if (last[p]) begin
              port_state[p] <= status.release_desc[p] ? STALL : FIRST;
            end else if (status.release_desc[p]) begin
              // Drop the held descriptor and ask again
              port_state[p] <= WAIT;
            end
          end
        endcase
      end
    end
  end

  // Latch the packet's descriptor on its first beat
  always_ff @(posedge clk) begin
    for (int p = 0; p < IF_COUNT; p++) begin
      if ((port_state[p] == FIRST) && acc[p]) begin
        pkt_desc[p] <= next_desc[p];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/stream_tagger.sv
// Per-port stream gating, tdest and tuser stamping
// and a two-entry output buffer per port
`timescale 1ns/1ps
`default_nettype none

module stream_tagger #(
  parameter int IF_COUNT = lb_pkg::IF_COUNT
) (
  input  logic                            clk,
  input  logic                            rst_r,
  input  lb_pkg::data_t    [IF_COUNT-1:0] in_tdata,
  input  logic             [IF_COUNT-1:0] in_tvalid,
  input  logic             [IF_COUNT-1:0] in_tlast,
  output logic             [IF_COUNT-1:0] in_tready,
  input  logic             [IF_COUNT-1:0] port_open,
  input  lb_pkg::dest_t    [IF_COUNT-1:0] port_dest,
  output lb_pkg::data_t    [IF_COUNT-1:0] out_tdata,
  output logic             [IF_COUNT-1:0] out_tvalid,
  input  logic             [IF_COUNT-1:0] out_tready,
  output logic             [IF_COUNT-1:0] out_tlast,
  output lb_pkg::dest_t    [IF_COUNT-1:0] out_tdest,
  output lb_pkg::port_id_t [IF_COUNT-1:0] out_tuser
);
  import lb_pkg::*;

  for (genvar p = 0; p < IF_COUNT; p++) begin : g_port
    data_t    buf_data [2];
    logic     buf_last [2];
    dest_t    buf_dest [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       open_valid;
    logic       push;
    logic       pop;

    // A stalled port neither offers nor accepts beats
    assign open_valid   = in_tvalid[p] && port_open[p];
    assign in_tready[p] = port_open[p] && (count != 2'd2);
    assign push         = open_valid && in_tready[p];
    assign pop          = out_tvalid[p] && out_tready[p];

    assign out_tvalid[p] = (count != 2'd0);
    assign out_tdata[p]  = buf_data[rd_ptr];
    assign out_tlast[p]  = buf_last[rd_ptr];
    assign out_tdest[p]  = buf_dest[rd_ptr];
    // Each output lane carries beats of its own source port only
    assign out_tuser[p]  = port_id_t'(p);

    always_ff @(posedge clk) begin
      if (push) begin
        buf_data[wr_ptr] <= in_tdata[p];
        buf_last[wr_ptr] <= in_tlast[p];
        buf_dest[wr_ptr] <= port_dest[p];
      end
    end

    always_ff @(posedge clk) begin
      if (rst_r) begin
        wr_ptr <= 1'b0;
        rd_ptr <= 1'b0;
        count  <= 2'd0;
      end else begin
        if (push) wr_ptr <= ~wr_ptr;
        if (pop) rd_ptr <= ~rd_ptr;
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/host_cmd_regs.sv
// Host command decode, core enable and income masks,
// descriptor release pulses and the status readback mux
`timescale 1ns/1ps
`default_nettype none

module host_cmd_regs #(
  parameter int IF_COUNT   = lb_pkg::IF_COUNT,
  parameter int CORE_COUNT = lb_pkg::CORE_COUNT
) (
  input  logic        clk,
  input  logic        rst_r,
  input  logic [31:0] host_cmd,
  input  logic [31:0] host_cmd_wr_data,
  input  logic        host_cmd_valid,
  lb_status_if.regs   status,
  output logic [31:0] host_cmd_rd_data
);
  import lb_pkg::*;

  logic        cmd_wr_r;
  logic [4:0]  cmd_sel_r;
  logic [3:0]  cmd_idx_r;
  logic [31:0] wr_data_r;
  logic [31:0] rd_data_n;
  core_id_t    core_sel;
  port_id_t    port_sel;
  dest_t       stat_desc;

  // First stage registers the command fields
  always_ff @(posedge clk) begin
    cmd_sel_r <= {host_cmd[30], host_cmd[3:0]};
    cmd_idx_r <= host_cmd[7:4];
    wr_data_r <= host_cmd_wr_data;
    if (rst_r) begin
      cmd_wr_r <= 1'b0;
    end else begin
      cmd_wr_r <= host_cmd_valid && host_cmd[31] && host_cmd[29];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      status.enabled_cores <= '0;
      status.income_cores  <= '0;
      status.release_desc  <= '0;
    end else begin
      status.release_desc <= '0;
      if (cmd_wr_r) begin
        case (cmd_sel_r)
          REG_ENABLED: begin
            // Disabled cores stop receiving packets too
            status.enabled_cores <= core_mask_t'(wr_data_r);
            status.income_cores  <= status.income_cores & core_mask_t'(wr_data_r);
          end
          REG_INCOME:  status.income_cores <= core_mask_t'(wr_data_r) & status.enabled_cores;
          REG_RELEASE: status.release_desc <= port_mask_t'(wr_data_r);
          default: ;
        endcase
      end
    end
  end

  assign core_sel  = core_id_t'(cmd_idx_r);
  assign port_sel  = port_id_t'(cmd_idx_r);
  assign stat_desc = status.port_descs[port_sel];

  always_comb begin
    case (cmd_sel_r)
      REG_ENABLED: rd_data_n = 32'(status.enabled_cores);
      REG_INCOME:  rd_data_n = 32'(status.income_cores);
      REG_SLOTS:   rd_data_n = 32'(status.slot_counts[core_sel]);
      REG_PORT_STAT: begin
        if (int'(cmd_idx_r) < IF_COUNT) begin
          rd_data_n = {14'd0, status.port_states[port_sel],
                       8'(stat_desc[TAG_WIDTH +: CORE_ID_WIDTH]),
                       8'(stat_desc[TAG_WIDTH-1:0])};
        end else begin
          rd_data_n = READ_DEFAULT;
        end
      end
      default:     rd_data_n = READ_DEFAULT;
    endcase
  end

  // Second stage, read data valid two cycles after the command
  always_ff @(posedge clk) begin
    host_cmd_rd_data <= rd_data_n;
  end

endmodule

`default_nettype wire

//--- hw/lb_top.sv
// Load balancer receive top level
// Connects host registers, slot pool, dispatcher and stream tagger
`timescale 1ns/1ps
`default_nettype none

module lb_top #(
  parameter int IF_COUNT   = lb_pkg::IF_COUNT,
  parameter int CORE_COUNT = lb_pkg::CORE_COUNT,
  parameter int SLOT_COUNT = lb_pkg::SLOT_COUNT
) (
  input  logic                            clk,
  input  logic                            rst_r,
  input  lb_pkg::data_t    [IF_COUNT-1:0] in_tdata,
  input  logic             [IF_COUNT-1:0] in_tvalid,
  input  logic             [IF_COUNT-1:0] in_tlast,
  output logic             [IF_COUNT-1:0] in_tready,
  output lb_pkg::data_t    [IF_COUNT-1:0] out_tdata,
  output logic             [IF_COUNT-1:0] out_tvalid,
  input  logic             [IF_COUNT-1:0] out_tready,
  output logic             [IF_COUNT-1:0] out_tlast,
  output lb_pkg::dest_t    [IF_COUNT-1:0] out_tdest,
  output lb_pkg::port_id_t [IF_COUNT-1:0] out_tuser,
  input  logic                            slot_return_valid,
  input  lb_pkg::core_id_t                slot_return_core,
  input  logic             [31:0]         host_cmd,
  input  logic             [31:0]         host_cmd_wr_data,
  input  logic                            host_cmd_valid,
  output logic             [31:0]         host_cmd_rd_data
);
  import lb_pkg::*;

  logic  [IF_COUNT-1:0] port_open;
  dest_t [IF_COUNT-1:0] port_dest;

  desc_if u_desc_if ();

  lb_status_if #(
    .IF_COUNT   (IF_COUNT),
    .CORE_COUNT (CORE_COUNT)
  ) u_status_if ();

  host_cmd_regs #(
    .IF_COUNT   (IF_COUNT),
    .CORE_COUNT (CORE_COUNT)
  ) u_host_cmd_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .status           (u_status_if),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  slot_pool #(
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) u_slot_pool (
    .clk               (clk),
    .rst_r             (rst_r),
    .slot_return_valid (slot_return_valid),
    .slot_return_core  (slot_return_core),
    .desc              (u_desc_if),
    .status            (u_status_if)
  );

  desc_dispatch #(
    .IF_COUNT (IF_COUNT)
  ) u_desc_dispatch (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_tvalid (in_tvalid),
    .in_tlast  (in_tlast),
    .in_tready (in_tready),
    .desc      (u_desc_if),
    .status    (u_status_if),
    .port_open (port_open),
    .port_dest (port_dest)
  );

  stream_tagger #(
    .IF_COUNT (IF_COUNT)
  ) u_stream_tagger (
    .clk        (clk),
    .rst_r      (rst_r),
    .in_tdata   (in_tdata),
    .in_tvalid  (in_tvalid),
    .in_tlast   (in_tlast),
    .in_tready  (in_tready),
    .port_open  (port_open),
    .port_dest  (port_dest),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tlast  (out_tlast),
    .out_tdest  (out_tdest),
    .out_tuser  (out_tuser)
  );

endmodule

`default_nettype wire

//--- tests/lb_props.sv
// Output stream properties of the stream tagger, bound into every instance
`timescale 1ns/1ps
`default_nettype none

module lb_props #(
  parameter int IF_COUNT = lb_pkg::IF_COUNT
) (
  input logic                         clk,
  input logic                         rst_r,
  input logic          [IF_COUNT-1:0] in_tvalid,
  input logic          [IF_COUNT-1:0] in_tready,
  input lb_pkg::data_t [IF_COUNT-1:0] out_tdata,
  input logic          [IF_COUNT-1:0] out_tvalid,
  input logic          [IF_COUNT-1:0] out_tready,
  input logic          [IF_COUNT-1:0] out_tlast,
  input lb_pkg::dest_t [IF_COUNT-1:0] out_tdest
);
  import lb_pkg::*;

  logic  [IF_COUNT-1:0] seen_beat;
  logic  [IF_COUNT-1:0] in_pkt;
  dest_t [IF_COUNT-1:0] pkt_dest;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      seen_beat <= '0;
      in_pkt    <= '0;
    end else begin
      seen_beat <= seen_beat | (in_tvalid & in_tready);
      for (int p = 0; p < IF_COUNT; p++) begin
        if (out_tvalid[p] && out_tready[p]) begin
          in_pkt[p] <= !out_tlast[p];
          // Destination of the packet as its first beat leaves
          if (!in_pkt[p]) pkt_dest[p] <= out_tdest[p];
        end
      end
    end
  end

  for (genvar p = 0; p < IF_COUNT; p++) begin : g_port
    hold_until_ready: assert property (@(posedge clk) disable iff (rst_r)
      out_tvalid[p] && !out_tready[p] |=>
        out_tvalid[p] && $stable(out_tdata[p]) && $stable(out_tdest[p]) &&
        $stable(out_tlast[p]))
      else $error("port %0d output changed while stalled", p);

    dest_in_packet: assert property (@(posedge clk) disable iff (rst_r)
      out_tvalid[p] && in_pkt[p] |-> out_tdest[p] == pkt_dest[p])
      else $error("port %0d tdest changed inside a packet", p);

    no_beat_from_nothing: assert property (@(posedge clk) disable iff (rst_r)
      !seen_beat[p] |-> !out_tvalid[p])
      else $error("port %0d output valid before any accepted beat", p);
  end

endmodule

bind stream_tagger lb_props #(
  .IF_COUNT (IF_COUNT)
) u_lb_props (
  .clk        (clk),
  .rst_r      (rst_r),
  .in_tvalid  (in_tvalid),
  .in_tready  (in_tready),
  .out_tdata  (out_tdata),
  .out_tvalid (out_tvalid),
  .out_tready (out_tready),
  .out_tlast  (out_tlast),
  .out_tdest  (out_tdest)
);

`default_nettype wire

//--- tests/lb_tb.sv
// Directed testbench for the load balancer receive path
// Reset values, core masks, single core flow, balancing, back-pressure and release
`timescale 1ns/1ps
`default_nettype none

module lb_tb;
  import lb_pkg::*;

  localparam int PKTS = 6;

  logic                    clk;
  logic                    rst_r;
  data_t    [IF_COUNT-1:0] in_tdata;
  logic     [IF_COUNT-1:0] in_tvalid;
  logic     [IF_COUNT-1:0] in_tlast;
  logic     [IF_COUNT-1:0] in_tready;
  data_t    [IF_COUNT-1:0] out_tdata;
  logic     [IF_COUNT-1:0] out_tvalid;
  logic     [IF_COUNT-1:0] out_tready;
  logic     [IF_COUNT-1:0] out_tlast;
  dest_t    [IF_COUNT-1:0] out_tdest;
  port_id_t [IF_COUNT-1:0] out_tuser;
  logic                    slot_return_valid;
  core_id_t                slot_return_core;
  logic     [31:0]         host_cmd;
  logic     [31:0]         host_cmd_wr_data;
  logic                    host_cmd_valid;
  logic     [31:0]         host_cmd_rd_data;

  integer     seed;
  int         errors;
  int         test_errors;
  int         tests_run;
  logic       backpressure;
  core_mask_t exp_income;
  int         tx_seq [IF_COUNT];
  int         rx_seq [IF_COUNT];
  int         rx_pkt [IF_COUNT];
  int         rx_beat [IF_COUNT];
  dest_t      rx_dest [IF_COUNT];
  dest_t      head_dest [$];

  lb_top #(
    .IF_COUNT   (IF_COUNT),
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) u_lb_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random back-pressure on the core side
  always @(negedge clk) begin
    if (backpressure) begin
      out_tready = port_mask_t'($random(seed));
    end else begin
      out_tready = '1;
    end
  end

  function automatic data_t beat_word(input int p, input int seq);
    return {8'(p), 24'(seq), 32'(seq) * 32'h9E37_79B9};
  endfunction

  function automatic int pkt_len(input int p, input int k);
    return 1 + ((3 * k + p) % 4);
  endfunction

  // Bit 30 from the register code's port select, index in bits 7:4
  function automatic logic [31:0] reg_cmd(input logic [4:0] r, input int idx);
    return {1'b0, r[4], 22'd0, 4'(idx), r[3:0]};
  endfunction

  task automatic flag_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_run();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic run_timeout(input string what);
    $display("Timeout: %s", what);
    errors++;
    finish_run();
  endtask

  task automatic test_done(input string name);
    $display("Test %s finished with %0d errors", name, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  task automatic check_beat(input int p);
    data_t exp_data;
    logic  exp_last;
    exp_data = beat_word(p, rx_seq[p]);
    exp_last = (rx_beat[p] == pkt_len(p, rx_pkt[p]) - 1);
    if (out_tdata[p] !== exp_data) begin
      flag_error($sformatf("port %0d beat %0d data %h, expected %h",
                           p, rx_seq[p], out_tdata[p], exp_data));
    end
    if (out_tlast[p] !== exp_last) begin
      flag_error($sformatf("port %0d beat %0d tlast %b", p, rx_seq[p], out_tlast[p]));
    end
    if (out_tuser[p] !== port_id_t'(p)) begin
      flag_error($sformatf("port %0d tuser %0d", p, out_tuser[p]));
    end
    if (exp_income[out_tdest[p][TAG_WIDTH +: CORE_ID_WIDTH]] !== 1'b1) begin
      flag_error($sformatf("port %0d tdest %h outside income mask %h",
                           p, out_tdest[p], exp_income));
    end
    if (rx_beat[p] == 0) begin
      rx_dest[p] = out_tdest[p];
      if (p == 0) begin
        head_dest.push_back(out_tdest[p]);
      end
    end else if (out_tdest[p] !== rx_dest[p]) begin
      flag_error($sformatf("port %0d tdest changed inside a packet", p));
    end
    rx_seq[p]++;
    if (exp_last) begin
      rx_pkt[p]++;
      rx_beat[p] = 0;
    end else begin
      rx_beat[p]++;
    end
  endtask

  // Output monitor, samples before the edge updates the DUT
  always @(posedge clk) begin
    if (!rst_r) begin
      for (int p = 0; p < IF_COUNT; p++) begin
        if (out_tvalid[p] && out_tready[p]) begin
          check_beat(p);
        end
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst_r             = 1'b1;
    in_tdata          = '0;
    in_tvalid         = '0;
    in_tlast          = '0;
    backpressure      = 1'b0;
    slot_return_valid = 1'b0;
    slot_return_core  = '0;
    host_cmd          = '0;
    host_cmd_wr_data  = '0;
    host_cmd_valid    = 1'b0;
    exp_income        = '0;
    head_dest.delete();
    for (int p = 0; p < IF_COUNT; p++) begin
      tx_seq[p]  = 0;
      rx_seq[p]  = 0;
      rx_pkt[p]  = 0;
      rx_beat[p] = 0;
    end
    repeat (4) @(negedge clk);
    rst_r = 1'b0;
  endtask

  task automatic host_write(input logic [31:0] cmd, input logic [31:0] data);
    @(negedge clk);
    host_cmd         = cmd | 32'hA000_0000;
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    @(negedge clk);
  endtask

  // Read data shows two cycles after the command
  task automatic host_read(input logic [31:0] cmd, output logic [31:0] data);
    @(negedge clk);
    host_cmd       = cmd;
    host_cmd_valid = 1'b0;
    repeat (2) @(negedge clk);
    data = host_cmd_rd_data;
  endtask

  task automatic send_packets(input int p, input int count);
    int len;
    int cycles;
    for (int k = 0; k < count; k++) begin
      len = pkt_len(p, k);
      for (int b = 0; b < len; b++) begin
        @(negedge clk);
        in_tdata[p]  = beat_word(p, tx_seq[p]);
        in_tlast[p]  = (b == len - 1);
        in_tvalid[p] = 1'b1;
        cycles = 0;
        while (!in_tready[p]) begin
          @(negedge clk);
          cycles++;
          if (cycles > 500) begin
            run_timeout($sformatf("port %0d never accepted beat %0d", p, tx_seq[p]));
          end
        end
        tx_seq[p]++;
      end
    end
    @(negedge clk);
    in_tvalid[p] = 1'b0;
  endtask

  task automatic wait_delivered(input int p, input int pkts);
    int cycles;
    cycles = 0;
    while (rx_pkt[p] < pkts) begin
      @(negedge clk);
      cycles++;
      if (cycles > 3000) begin
        run_timeout($sformatf("port %0d delivered only %0d packets", p, rx_pkt[p]));
      end
    end
  endtask

  task automatic reset_values();
    logic [31:0] rd;
    apply_reset();
    if (in_tready !== '0 || out_tvalid !== '0) begin
      flag_error($sformatf("in_tready %b out_tvalid %b after reset", in_tready, out_tvalid));
    end
    host_read(reg_cmd(REG_ENABLED, 0), rd);
    if (rd !== 32'd0) flag_error($sformatf("REG_ENABLED read %h", rd));
    host_read(reg_cmd(REG_INCOME, 0), rd);
    if (rd !== 32'd0) flag_error($sformatf("REG_INCOME read %h", rd));
    for (int c = 0; c < CORE_COUNT; c++) begin
      host_read(reg_cmd(REG_SLOTS, c), rd);
      if (rd !== 32'(SLOT_COUNT)) flag_error($sformatf("core %0d slots %0d", c, rd));
    end
    host_read(reg_cmd(5'h05, 0), rd);
    if (rd !== 32'hFEFE_FEFE) flag_error($sformatf("unknown register read %h", rd));
    test_done("reset_values");
  endtask

  task automatic core_masks();
    logic [31:0] rd;
    apply_reset();
    host_write(reg_cmd(REG_INCOME, 0), 32'hFF);
    host_read(reg_cmd(REG_INCOME, 0), rd);
    if (rd !== 32'h00) flag_error($sformatf("income without enables read %h", rd));
    host_write(reg_cmd(REG_ENABLED, 0), 32'h0F);
    host_write(reg_cmd(REG_INCOME, 0), 32'h3C);
    host_read(reg_cmd(REG_INCOME, 0), rd);
    if (rd !== 32'h0C) flag_error($sformatf("income read %h, expected 0c", rd));
    host_write(reg_cmd(REG_ENABLED, 0), 32'h07);
    host_read(reg_cmd(REG_INCOME, 0), rd);
    if (rd !== 32'h04) flag_error($sformatf("narrowed income read %h, expected 04", rd));
    host_read(reg_cmd(REG_ENABLED, 0), rd);
    if (rd !== 32'h07) flag_error($sformatf("enabled read %h, expected 07", rd));
    test_done("core_masks");
  endtask

  task automatic single_core_flow();
    int    exp_tag;
    dest_t exp_dest;
    apply_reset();
    host_write(reg_cmd(REG_ENABLED, 0), 32'hFF);
    exp_income = 8'h04;
    host_write(reg_cmd(REG_INCOME, 0), 32'h04);
    send_packets(0, 3);
    wait_delivered(0, 3);
    if (head_dest.size() != 3) begin
      flag_error($sformatf("port 0 sent %0d packet heads", head_dest.size()));
    end else begin
      for (int k = 0; k < 3; k++) begin
        // Idle ports 1 and 2 each take one tag right after port 0's first
        exp_tag  = (k == 0) ? 0 : IF_COUNT - 1 + k;
        exp_dest = {core_id_t'(2), tag_t'(exp_tag)};
        if (head_dest[k] !== exp_dest) begin
          flag_error($sformatf("packet %0d tdest %h, expected %h", k, head_dest[k], exp_dest));
        end
      end
    end
    test_done("single_core_flow");
  endtask

  task automatic slot_balance();
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] rd;
    apply_reset();
    host_write(reg_cmd(REG_ENABLED, 0), 32'hFF);
    exp_income = 8'h03;
    host_write(reg_cmd(REG_INCOME, 0), 32'h03);
    send_packets(0, PKTS);
    wait_delivered(0, PKTS);
    host_read(reg_cmd(REG_SLOTS, 0), c0);
    host_read(reg_cmd(REG_SLOTS, 1), c1);
    if ((c0 > c1) || (c1 - c0 > 32'd1)) begin
      flag_error($sformatf("unbalanced slots core0 %0d core1 %0d", c0, c1));
    end
    @(negedge clk);
    slot_return_valid = 1'b1;
    slot_return_core  = core_id_t'(1);
    @(negedge clk);
    slot_return_valid = 1'b0;
    host_read(reg_cmd(REG_SLOTS, 1), rd);
    if (rd !== c1 + 32'd1) flag_error($sformatf("core 1 slots %0d after return", rd));
    test_done("slot_balance");
  endtask

  task automatic all_ports_backpressure();
    apply_reset();
    host_write(reg_cmd(REG_ENABLED, 0), 32'hFF);
    exp_income = 8'h5A;
    host_write(reg_cmd(REG_INCOME, 0), 32'h5A);
    backpressure = 1'b1;
    for (int p = 0; p < IF_COUNT; p++) begin
      fork
        automatic int port = p;
        send_packets(port, PKTS);
      join_none
    end
    wait fork;
    for (int p = 0; p < IF_COUNT; p++) begin
      wait_delivered(p, PKTS);
    end
    backpressure = 1'b0;
    for (int p = 0; p < IF_COUNT; p++) begin
      if (rx_seq[p] != tx_seq[p]) begin
        flag_error($sformatf("port %0d sent %0d beats, got %0d", p, tx_seq[p], rx_seq[p]));
      end
    end
    test_done("all_ports_backpressure");
  endtask

  task automatic port_release();
    logic [31:0] rd;
    int          polls;
    apply_reset();
    host_write(reg_cmd(REG_ENABLED, 0), 32'hFF);
    host_write(reg_cmd(REG_INCOME, 0), 32'h10);
    rd    = '0;
    polls = 0;
    while (rd[17:16] != 2'd1) begin
      host_read(reg_cmd(REG_PORT_STAT, 1), rd);
      polls++;
      if (polls > 20) run_timeout("port 1 never reached FIRST");
    end
    if (rd[15:8] !== 8'd4) flag_error($sformatf("port 1 holds core %0d", rd[15:8]));
    host_write(reg_cmd(REG_INCOME, 0), 32'h00);
    host_write(reg_cmd(REG_RELEASE, 0), 32'h2);
    host_read(reg_cmd(REG_PORT_STAT, 1), rd);
    if (rd[17:16] !== 2'd0) flag_error($sformatf("port 1 state %0d after release", rd[17:16]));
    test_done("port_release");
  endtask

  initial begin
    seed              = 32'h35f6;
    errors            = 0;
    test_errors       = 0;
    tests_run         = 0;
    rst_r             = 1'b1;
    in_tdata          = '0;
    in_tvalid         = '0;
    in_tlast          = '0;
    out_tready        = '1;
    backpressure      = 1'b0;
    exp_income        = '0;
    slot_return_valid = 1'b0;
    slot_return_core  = '0;
    host_cmd          = '0;
    host_cmd_wr_data  = '0;
    host_cmd_valid    = 1'b0;
    reset_values();
    core_masks();
    single_core_flow();
    slot_balance();
    all_ports_backpressure();
    port_release();
    finish_run();
  end

endmodule

`default_nettype wire

//--- all.f
hw/lb_pkg.sv
hw/lb_if.sv
hw/slot_pool.sv
hw/desc_dispatch.sv
hw/stream_tagger.sv
hw/host_cmd_regs.sv
hw/lb_top.sv
tests/lb_props.sv
tests/lb_tb.sv

//--- Makefile
# Verilator build and run of the load balancer testbench
VERILATOR ?= verilator
TOP       ?= lb_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
